// File: sources.f
+incdir+source
source/pu_io_pkg.sv
source/tag_lookup_pkg.sv
source/rr_arbiter.sv
source/tag_lookup_engine.sv
source/tag_lookup_mem.sv
source/pu_tag_req.sv
dv/tb_pu_tag_req.sv

// File: Bender.yml
package:
  name: pu_tag_req

sources:
  - include_dirs:
      - source
    files:
      - source/pu_io_pkg.sv
      - source/tag_lookup_pkg.sv
      - source/rr_arbiter.sv
      - source/tag_lookup_engine.sv
      - source/tag_lookup_mem.sv
      - source/pu_tag_req.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_pu_tag_req.sv

// File: dv/tb_pu_tag_req.sv
// Testbench for the PU tag lookup request block.
// Register port, table hits and misses, round-robin grants and random traffic.

`include "tag_defines.svh"

module tb_pu_tag_req;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [3:0]  status;
		logic [31:0] result;
		logic [2:0]  num;
		logic [1:0]  pid;
		logic [31:0] ack_cycle;
	} expect_t;

	localparam int drain_limit = 200;

	logic                        clk;
	logic                        rst;
	logic [`TAG_NUM_PU-1:0]      io_req;
	logic [`TAG_NUM_PU-1:0]      io_cmd_wr;
	logic [`TAG_NUM_PU-1:0]      io_ack;
	pu_io_pkg::io_addr_t         io_cmd_addr [`TAG_NUM_PU];
	pu_io_pkg::io_data_t         io_cmd_wdata [`TAG_NUM_PU];
	pu_io_pkg::reg_word_t        reg_addr;
	pu_io_pkg::reg_word_t        reg_din;
	logic                        reg_rd;
	logic                        reg_wr;
	logic                        reg_ms_tag_hash_table;
	logic                        reg_ms_tag_value;
	logic                        tag_hash_table_mem_ack;
	pu_io_pkg::reg_word_t        tag_hash_table_mem_rdata;
	logic                        tag_value_mem_ack;
	pu_io_pkg::reg_word_t        tag_value_mem_rdata;
	logic                        tag_lookup_valid;
	tag_lookup_pkg::tag_value_t  tag_lookup_result;
	logic [2:0]                  tag_lookup_result_num;
	pu_io_pkg::pu_id_t           tag_lookup_result_pid;
	logic                        tag_lookup_status_valid;
	tag_lookup_pkg::tag_status_t tag_lookup_status;
	pu_io_pkg::pu_id_t           tag_lookup_status_pid;

	// Shadow of the DUT memories.
	logic [25:0] shadow_table [2][64];
	logic [31:0] shadow_value [64];

	expect_t          expq [$];
	expect_t          exp_e;
	logic             exp_hit;
	logic [3:0]       seen_status = '0;
	logic [15:0]      pu_key [`TAG_NUM_PU];
	logic [3:0]       outstanding = '0;
	int               issued [`TAG_NUM_PU];
	int               acked [`TAG_NUM_PU];
	logic [31:0]      cycle = '0;
	logic [31:0]      last_ack_cycle = '0;
	logic             have_ack = 1'b0;
	logic [1:0]       last_pid = 2'd0;
	int               rot_left = 0;
	int               error_count = 0;
	int               tests_run = 0;
	int               tests_failed = 0;
	logic             timed_out = 1'b0;

	pu_tag_req i_pu_tag_req (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ------------------------------
	// Reference model from the hash and bucket rules.
	function automatic logic [5:0] table0_index(input logic [15:0] key);
		return key[5:0];
	endfunction

	function automatic logic [5:0] table1_index(input logic [15:0] key);
		return key[11:6] ^ {2'b00, key[15:12]};
	endfunction

	function automatic logic [25:0] make_bucket(input logic valid, input logic [15:0] key,
		input logic [5:0] vidx, input logic [2:0] num);
		return {valid, key, vidx, num};
	endfunction

	function automatic expect_t reference_lookup(input logic [15:0] key, input logic [1:0] pid);
		expect_t     e;
		logic [25:0] b0;
		logic [25:0] b1;
		b0 = shadow_table[0][table0_index(key)];
		b1 = shadow_table[1][table1_index(key)];
		e = '0;
		e.pid = pid;
		if (b0[25] && b0[24:9] == key) begin
			e.status = 4'd1;
			e.result = shadow_value[b0[8:3]];
			e.num = b0[2:0];
		end else if (b1[25] && b1[24:9] == key) begin
			e.status = 4'd2;
			e.result = shadow_value[b1[8:3]];
			e.num = b1[2:0];
		end else begin
			e.status = 4'd8;
		end
		return e;
	endfunction

	function automatic void report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %s expected %h got %h", name, expected, actual);
		error_count++;
	endfunction

	function automatic void report_problem(input string msg);
		$display("%s", msg);
		error_count++;
	endfunction

	// ------------------------------
	// Response checker.
	always @(negedge clk) begin
		if (!rst) begin
			for (int i = 0; i < `TAG_NUM_PU; i++) begin
				if (io_ack[i]) begin
					if (!outstanding[i])
						report_problem($sformatf("io_ack for PU %0d without a request", i));
					if (have_ack && (cycle - last_ack_cycle) < 8)
						report_problem($sformatf("io_ack %0d cycles after the previous one",
							cycle - last_ack_cycle));
					if (rot_left > 0) begin
						if (2'(i) != 2'(last_pid + 1))
							report_problem($sformatf("grant to PU %0d breaks round-robin order", i));
						rot_left--;
					end
					exp_e = reference_lookup(pu_key[i], 2'(i));
					exp_e.ack_cycle = cycle;
					expq.push_back(exp_e);
					outstanding[i] = 1'b0;
					acked[i]++;
					last_pid = 2'(i);
					last_ack_cycle = cycle;
					have_ack = 1'b1;
				end
			end
			if (tag_lookup_status_valid) begin
				seen_status = tag_lookup_status;
				if (expq.size() == 0) begin
					report_problem("status pulse with no lookup in flight");
				end else begin
					exp_e = expq.pop_front();
					exp_hit = (exp_e.status != 4'd8);
					if (tag_lookup_status !== exp_e.status)
						report_mismatch("tag_lookup_status", exp_e.status, tag_lookup_status);
					if (tag_lookup_status_pid !== exp_e.pid)
						report_mismatch("tag_lookup_status_pid", exp_e.pid, tag_lookup_status_pid);
					if (tag_lookup_valid !== exp_hit)
						report_problem(exp_hit ? "no tag_lookup_valid pulse on a hit" :
							"tag_lookup_valid pulse on a miss");
					if (cycle - exp_e.ack_cycle != (exp_hit ? 4 : 2))
						report_problem($sformatf("status %0d cycles after io_ack, expected %0d",
							cycle - exp_e.ack_cycle, exp_hit ? 4 : 2));
					if (exp_hit) begin
						if (tag_lookup_result !== exp_e.result)
							report_mismatch("tag_lookup_result", exp_e.result, tag_lookup_result);
						if (tag_lookup_result_num !== exp_e.num)
							report_mismatch("tag_lookup_result_num", exp_e.num,
								tag_lookup_result_num);
						if (tag_lookup_result_pid !== exp_e.pid)
							report_mismatch("tag_lookup_result_pid", exp_e.pid,
								tag_lookup_result_pid);
					end
				end
			end else if (tag_lookup_valid) begin
				report_problem("tag_lookup_valid without a status pulse");
			end
		end
	end

	// ------------------------------
	// Register port access with the ack one cycle after the strobe.
	task automatic reg_access(input logic write, input logic to_table, input logic [31:0] addr,
		input logic [31:0] din, output logic [31:0] rdata);
		@(posedge clk);
		reg_wr <= write;
		reg_rd <= !write;
		reg_ms_tag_hash_table <= to_table;
		reg_ms_tag_value <= !to_table;
		reg_addr <= addr;
		reg_din <= din;
		@(negedge clk);
		if ((to_table ? tag_hash_table_mem_ack : tag_value_mem_ack) !== 1'b0)
			report_problem("register ack in the same cycle as the access");
		@(posedge clk);
		reg_wr <= 1'b0;
		reg_rd <= 1'b0;
		reg_ms_tag_hash_table <= 1'b0;
		reg_ms_tag_value <= 1'b0;
		@(negedge clk);
		if ((to_table ? tag_hash_table_mem_ack : tag_value_mem_ack) !== 1'b1)
			report_problem("register ack missing one cycle after the access");
		rdata = to_table ? tag_hash_table_mem_rdata : tag_value_mem_rdata;
		if (write && rdata !== '0)
			report_mismatch(to_table ? "tag_hash_table_mem_rdata" : "tag_value_mem_rdata",
				32'd0, rdata);
	endtask

	task automatic write_bucket(input logic tbl, input logic [5:0] idx, input logic [25:0] b);
		logic [31:0] rdata;
		reg_access(1'b1, 1'b1, {25'd0, tbl, idx}, {6'd0, b}, rdata);
		shadow_table[tbl][idx] = b;
	endtask

	task automatic write_value(input logic [5:0] idx, input logic [31:0] value);
		logic [31:0] rdata;
		reg_access(1'b1, 1'b0, {26'd0, idx}, value, rdata);
		shadow_value[idx] = value;
	endtask

	// ------------------------------
	// PU request drive.
	task automatic drive_request(input logic [1:0] pid, input logic [15:0] key);
		io_req[pid] <= 1'b1;
		io_cmd_wr[pid] <= 1'b1;
		io_cmd_addr[pid] <= {`TAG_REQ_REGION, 12'($urandom)};
		io_cmd_wdata[pid] <= {16'($urandom), key};
		pu_key[pid] = key;
		outstanding[pid] = 1'b1;
		issued[pid]++;
	endtask

	task automatic drive_bad_request(input logic [1:0] pid, input logic without_write);
		logic [3:0] region;
		region = 4'($urandom);
		if (region == `TAG_REQ_REGION)
			region = 4'h5;
		io_req[pid] <= 1'b1;
		io_cmd_wr[pid] <= !without_write;
		io_cmd_addr[pid] <= {without_write ? `TAG_REQ_REGION : region, 12'($urandom)};
		io_cmd_wdata[pid] <= $urandom;
	endtask

	task automatic clear_requests();
		io_req <= '0;
		io_cmd_wr <= '0;
	endtask

	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while ((outstanding != '0 || expq.size() != 0) && n < drain_limit && !timed_out) begin
			@(negedge clk);
			n++;
		end
		if (!timed_out && (outstanding != '0 || expq.size() != 0)) begin
			report_problem($sformatf("timeout waiting for %s", what));
			timed_out = 1'b1;
		end
	endtask

	task automatic single_lookup(input logic [1:0] pid, input logic [15:0] key,
		input logic [3:0] want_status);
		seen_status = 4'd0;
		@(posedge clk);
		drive_request(pid, key);
		@(posedge clk);
		clear_requests();
		wait_drain($sformatf("lookup of key %h", key));
		if (!timed_out && seen_status !== want_status)
			report_mismatch("tag_lookup_status", want_status, seen_status);
	endtask

	// ------------------------------
	// Tests.
	task automatic test_register_port();
		logic [31:0] rdata;
		for (int t = 0; t < 2; t++) begin
			for (int i = 0; i < 64; i++) begin
				write_bucket(t[0], 6'(i), make_bucket($urandom_range(3) != 0, 16'($urandom),
					6'($urandom), 3'($urandom)));
			end
		end
		for (int i = 0; i < 64; i++)
			write_value(6'(i), $urandom);
		for (int t = 0; t < 2; t++) begin
			for (int i = 0; i < 64; i++) begin
				reg_access(1'b0, 1'b1, {25'd0, t[0], 6'(i)}, 32'd0, rdata);
				if (rdata !== {6'd0, shadow_table[t][i]})
					report_mismatch("tag_hash_table_mem_rdata", {6'd0, shadow_table[t][i]}, rdata);
			end
		end
		for (int i = 0; i < 64; i++) begin
			reg_access(1'b0, 1'b0, {26'd0, 6'(i)}, 32'd0, rdata);
			if (rdata !== shadow_value[i])
				report_mismatch("tag_value_mem_rdata", shadow_value[i], rdata);
		end
	endtask

	task automatic test_table0_hit();
		logic [15:0] key;
		key = 16'($urandom);
		write_bucket(1'b0, table0_index(key), make_bucket(1'b1, key, 6'($urandom), 3'($urandom)));
		write_bucket(1'b1, table1_index(key), make_bucket(1'b0, key, 6'($urandom), 3'($urandom)));
		single_lookup(2'd2, key, 4'd1);
	endtask

	task automatic test_table1_hit();
		logic [15:0] key;
		key = 16'($urandom);
		write_bucket(1'b0, table0_index(key), make_bucket(1'b1, key ^ 16'h8000, 6'($urandom), 3'd1));
		write_bucket(1'b1, table1_index(key), make_bucket(1'b1, key, 6'($urandom), 3'($urandom)));
		single_lookup(2'd1, key, 4'd2);
		// Key present in both tables.
		key = 16'($urandom);
		write_bucket(1'b0, table0_index(key), make_bucket(1'b1, key, 6'($urandom), 3'($urandom)));
		write_bucket(1'b1, table1_index(key), make_bucket(1'b1, key, 6'($urandom), 3'($urandom)));
		single_lookup(2'd3, key, 4'd1);
	endtask

	task automatic test_miss();
		logic [15:0] key;
		key = 16'($urandom);
		write_bucket(1'b0, table0_index(key), make_bucket(1'b0, key, 6'($urandom), 3'($urandom)));
		write_bucket(1'b1, table1_index(key), make_bucket(1'b1, key ^ 16'h0001, 6'($urandom), 3'd2));
		single_lookup(2'd0, key, 4'd8);
	endtask

	task automatic test_traffic();
		logic [15:0] key;
		logic [15:0] hit_keys [$];
		int          kind;
		repeat (8) begin
			key = 16'($urandom);
			if ($urandom_range(1) == 1)
				write_bucket(1'b1, table1_index(key), make_bucket(1'b1, key, 6'($urandom),
					3'($urandom)));
			else
				write_bucket(1'b0, table0_index(key), make_bucket(1'b1, key, 6'($urandom),
					3'($urandom)));
			hit_keys.push_back(key);
		end
		// All four PUs at once.
		rot_left = `TAG_NUM_PU;
		@(posedge clk);
		for (int i = 0; i < `TAG_NUM_PU; i++)
			drive_request(2'(i), hit_keys[i]);
		@(posedge clk);
		clear_requests();
		wait_drain("the four simultaneous lookups");
		repeat (400) begin
			@(posedge clk);
			clear_requests();
			for (int i = 0; i < `TAG_NUM_PU; i++) begin
				if (!outstanding[i] && $urandom_range(5) == 0) begin
					kind = $urandom_range(3);
					if (kind == 0)
						drive_bad_request(2'(i), 1'b0);
					else if (kind == 1)
						drive_bad_request(2'(i), 1'b1);
					else if ($urandom_range(1) == 1)
						drive_request(2'(i), hit_keys[$urandom_range(7)]);
					else
						drive_request(2'(i), 16'($urandom));
				end
			end
		end
		@(posedge clk);
		clear_requests();
		wait_drain("random traffic");
		for (int i = 0; i < `TAG_NUM_PU; i++) begin
			if (acked[i] != issued[i])
				report_problem($sformatf("PU %0d got %0d acks for %0d requests", i, acked[i],
					issued[i]));
		end
	endtask

	task automatic end_test(input int num, input string name, input int mark);
		tests_run++;
		if (error_count == mark) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", num, name, error_count - mark);
		end
	endtask

	// ------------------------------
	initial begin
		int seed_value;
		int mark;
		seed_value = $urandom(8492);
		rst = 1'b1;
		io_req = '0;
		io_cmd_wr = '0;
		reg_addr = '0;
		reg_din = '0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		reg_ms_tag_hash_table = 1'b0;
		reg_ms_tag_value = 1'b0;
		for (int i = 0; i < `TAG_NUM_PU; i++) begin
			io_cmd_addr[i] = '0;
			io_cmd_wdata[i] = '0;
			pu_key[i] = '0;
			issued[i] = 0;
			acked[i] = 0;
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		mark = error_count;
		test_register_port();
		end_test(1, "register port", mark);
		if (!timed_out) begin
			mark = error_count;
			test_table0_hit();
			end_test(2, "table 0 hit", mark);
		end
		if (!timed_out) begin
			mark = error_count;
			test_table1_hit();
			end_test(3, "table 1 and dual hit", mark);
		end
		if (!timed_out) begin
			mark = error_count;
			test_miss();
			end_test(4, "miss", mark);
		end
		if (!timed_out) begin
			mark = error_count;
			test_traffic();
			end_test(5, "arbitration and traffic", mark);
		end

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: source/pu_tag_req.sv
// PU tag lookup request block.
// Decodes PU requests, keeps one pending flag per PU, arbitrates them
// into the lookup engine and exposes the table register port.

`include "tag_defines.svh"

module pu_tag_req (
	input  logic                         clk,
	input  logic                         rst,

	input  logic [`TAG_NUM_PU-1:0]       io_req,
	input  logic [`TAG_NUM_PU-1:0]       io_cmd_wr,
	input  pu_io_pkg::io_addr_t          io_cmd_addr [`TAG_NUM_PU],
	input  pu_io_pkg::io_data_t          io_cmd_wdata [`TAG_NUM_PU],
	output logic [`TAG_NUM_PU-1:0]       io_ack,

	input  pu_io_pkg::reg_word_t         reg_addr,
	input  pu_io_pkg::reg_word_t         reg_din,
	input  logic                         reg_rd,
	input  logic                         reg_wr,
	input  logic                         reg_ms_tag_hash_table,
	input  logic                         reg_ms_tag_value,
	output logic                         tag_hash_table_mem_ack,
	output pu_io_pkg::reg_word_t         tag_hash_table_mem_rdata,
	output logic                         tag_value_mem_ack,
	output pu_io_pkg::reg_word_t         tag_value_mem_rdata,

	output logic                         tag_lookup_valid,
	output tag_lookup_pkg::tag_value_t   tag_lookup_result,
	output logic [2:0]                   tag_lookup_result_num,
	output pu_io_pkg::pu_id_t            tag_lookup_result_pid,
	output logic                         tag_lookup_status_valid,
	output tag_lookup_pkg::tag_status_t  tag_lookup_status,
	output pu_io_pkg::pu_id_t            tag_lookup_status_pid
);

	typedef logic [$clog2(`TAG_ARB_HOLDOFF+1)-1:0] holdoff_t;

	logic [`TAG_NUM_PU-1:0]      accept;
	logic [`TAG_NUM_PU-1:0]      pending;
	tag_lookup_pkg::tag_key_t    key_q [`TAG_NUM_PU];
	pu_io_pkg::pu_id_t           arb_sel;
	logic                        arb_gnt;
	logic                        arb_en;
	holdoff_t                    holdoff_cnt;

	logic                        tag_hash_table0_rd, tag_hash_table0_ack;
	logic                        tag_hash_table1_rd, tag_hash_table1_ack;
	logic                        tag_value_rd, tag_value_ack;
	tag_lookup_pkg::tag_index_t  tag_hash_table0_raddr, tag_hash_table1_raddr;
	tag_lookup_pkg::tag_index_t  tag_value_raddr;
	tag_lookup_pkg::tag_bucket_t tag_hash_table0_rdata, tag_hash_table1_rdata;
	tag_lookup_pkg::tag_value_t  tag_value_rdata;

	// Lookup request decode.
	always_comb begin
		for (int i = 0; i < `TAG_NUM_PU; i++) begin
			accept[i] = io_req[i] && io_cmd_wr[i] &&
				(io_cmd_addr[i][`TAG_IO_ADDR_NBITS-1 -: 4] == `TAG_REQ_REGION);
		end
	end

	// ------------------------------
	// Pending flags, acks and holdoff.
	always_ff @(posedge clk) begin
		if (rst) begin
			pending     <= '0;
			io_ack      <= '0;
			holdoff_cnt <= '0;
		end else begin
			for (int i = 0; i < `TAG_NUM_PU; i++) begin
				// A new request beats the clear.
				if (accept[i]) begin
					pending[i] <= 1'b1;
				end else if (arb_gnt && arb_sel == pu_io_pkg::pu_id_t'(i)) begin
					pending[i] <= 1'b0;
				end
				io_ack[i] <= arb_gnt && (arb_sel == pu_io_pkg::pu_id_t'(i));
			end
			if (arb_gnt) begin
				holdoff_cnt <= holdoff_t'(`TAG_ARB_HOLDOFF - 1);
			end else if (holdoff_cnt != '0) begin
				holdoff_cnt <= holdoff_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `TAG_NUM_PU; i++) begin
			if (accept[i]) begin
				key_q[i] <= io_cmd_wdata[i][`TAG_KEY_NBITS-1:0];
			end
		end
	end

	assign arb_en = ~arb_gnt & (holdoff_cnt == '0);

	// ------------------------------
	rr_arbiter u_rr_arbiter (
		.clk, .rst,
		.en(arb_en), .req(pending),
		.sel(arb_sel), .gnt(arb_gnt)
	);

	tag_lookup_engine u_tag_lookup_engine (
		.clk, .rst,
		.tag_key_valid(arb_gnt), .tag_key(key_q[arb_sel]), .tag_pid(arb_sel),
		.tag_hash_table0_ack, .tag_hash_table0_rdata,
		.tag_hash_table1_ack, .tag_hash_table1_rdata,
		.tag_value_ack, .tag_value_rdata,
		.tag_lookup_valid, .tag_lookup_result,
		.tag_lookup_result_num, .tag_lookup_result_pid,
		.tag_lookup_status_valid, .tag_lookup_status, .tag_lookup_status_pid,
		.tag_hash_table0_rd, .tag_hash_table0_raddr,
		.tag_hash_table1_rd, .tag_hash_table1_raddr,
		.tag_value_rd, .tag_value_raddr
	);

	tag_lookup_mem u_tag_lookup_mem (
		.clk, .rst,
		.reg_addr, .reg_din, .reg_rd, .reg_wr,
		.reg_ms_tag_hash_table, .reg_ms_tag_value,
		.tag_hash_table_mem_ack, .tag_hash_table_mem_rdata,
		.tag_value_mem_ack, .tag_value_mem_rdata,
		.tag_hash_table0_rd, .tag_hash_table0_raddr,
		.tag_hash_table1_rd, .tag_hash_table1_raddr,
		.tag_value_rd, .tag_value_raddr,
		.tag_hash_table0_ack, .tag_hash_table0_rdata,
		.tag_hash_table1_ack, .tag_hash_table1_rdata,
		.tag_value_ack, .tag_value_rdata
	);

endmodule

// File: source/tag_lookup_mem.sv
// Hash table and value memories.
// Registered lookup read ports plus a separate register access port.

`include "tag_defines.svh"

module tag_lookup_mem (
	input  logic                         clk,
	input  logic                         rst,

	input  pu_io_pkg::reg_word_t         reg_addr,
	input  pu_io_pkg::reg_word_t         reg_din,
	input  logic                         reg_rd,
	input  logic                         reg_wr,
	input  logic                         reg_ms_tag_hash_table,
	input  logic                         reg_ms_tag_value,

	output logic                         tag_hash_table_mem_ack,
	output pu_io_pkg::reg_word_t         tag_hash_table_mem_rdata,
	output logic                         tag_value_mem_ack,
	output pu_io_pkg::reg_word_t         tag_value_mem_rdata,

	input  logic                         tag_hash_table0_rd,
	input  tag_lookup_pkg::tag_index_t   tag_hash_table0_raddr,
	input  logic                         tag_hash_table1_rd,
	input  tag_lookup_pkg::tag_index_t   tag_hash_table1_raddr,
	input  logic                         tag_value_rd,
	input  tag_lookup_pkg::tag_index_t   tag_value_raddr,

	output logic                         tag_hash_table0_ack,
	output tag_lookup_pkg::tag_bucket_t  tag_hash_table0_rdata,
	output logic                         tag_hash_table1_ack,
	output tag_lookup_pkg::tag_bucket_t  tag_hash_table1_rdata,
	output logic                         tag_value_ack,
	output tag_lookup_pkg::tag_value_t   tag_value_rdata
);

	tag_lookup_pkg::tag_bucket_t table_mem [2][1 << `TAG_TABLE_DEPTH_NBITS];
	tag_lookup_pkg::tag_value_t  value_mem [1 << `TAG_VALUE_DEPTH_NBITS];

	logic                       reg_tsel;
	tag_lookup_pkg::tag_index_t reg_idx;

	// Bit 6 picks the table.
	assign reg_tsel = reg_addr[`TAG_TABLE_DEPTH_NBITS];
	assign reg_idx  = reg_addr[`TAG_TABLE_DEPTH_NBITS-1:0];

	// ------------------------------
	// Storage and read data.
	always_ff @(posedge clk) begin
		if (reg_wr && reg_ms_tag_hash_table) begin
			table_mem[reg_tsel][reg_idx] <= reg_din[`TAG_BUCKET_NBITS-1:0];
		end
		if (reg_wr && reg_ms_tag_value) begin
			value_mem[reg_idx] <= reg_din;
		end

		tag_hash_table0_rdata <= table_mem[0][tag_hash_table0_raddr];
		tag_hash_table1_rdata <= table_mem[1][tag_hash_table1_raddr];
		tag_value_rdata       <= value_mem[tag_value_raddr];

		// Writes read back as zero.
		if (reg_rd && reg_ms_tag_hash_table) begin
			tag_hash_table_mem_rdata <= {{(`TAG_REG_NBITS-`TAG_BUCKET_NBITS){1'b0}},
				table_mem[reg_tsel][reg_idx]};
		end else begin
			tag_hash_table_mem_rdata <= '0;
		end
		tag_value_mem_rdata <= (reg_rd && reg_ms_tag_value) ? value_mem[reg_idx] : '0;
	end

	// ------------------------------
	// Acks one cycle after each access.
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_hash_table_mem_ack <= 1'b0;
			tag_value_mem_ack      <= 1'b0;
			tag_hash_table0_ack    <= 1'b0;
			tag_hash_table1_ack    <= 1'b0;
			tag_value_ack          <= 1'b0;
		end else begin
			tag_hash_table_mem_ack <= (reg_rd | reg_wr) & reg_ms_tag_hash_table;
			tag_value_mem_ack      <= (reg_rd | reg_wr) & reg_ms_tag_value;
			tag_hash_table0_ack    <= tag_hash_table0_rd;
			tag_hash_table1_ack    <= tag_hash_table1_rd;
			tag_value_ack          <= tag_value_rd;
		end
	end

endmodule

// File: source/tag_lookup_engine.sv
// Two-way hash lookup engine.
// Reads both tables, then the value word on a hit, and reports result and status.

`include "tag_defines.svh"

module tag_lookup_engine (
	input  logic                         clk,
	input  logic                         rst,

	input  logic                         tag_key_valid,
	input  tag_lookup_pkg::tag_key_t     tag_key,
	input  pu_io_pkg::pu_id_t            tag_pid,

	input  logic                         tag_hash_table0_ack,
	input  tag_lookup_pkg::tag_bucket_t  tag_hash_table0_rdata,
	input  logic                         tag_hash_table1_ack,
	input  tag_lookup_pkg::tag_bucket_t  tag_hash_table1_rdata,
	input  logic                         tag_value_ack,
	input  tag_lookup_pkg::tag_value_t   tag_value_rdata,

	output logic                         tag_lookup_valid,
	output tag_lookup_pkg::tag_value_t   tag_lookup_result,
	output logic [2:0]                   tag_lookup_result_num,
	output pu_io_pkg::pu_id_t            tag_lookup_result_pid,
	output logic                         tag_lookup_status_valid,
	output tag_lookup_pkg::tag_status_t  tag_lookup_status,
	output pu_io_pkg::pu_id_t            tag_lookup_status_pid,

	output logic                         tag_hash_table0_rd,
	output tag_lookup_pkg::tag_index_t   tag_hash_table0_raddr,
	output logic                         tag_hash_table1_rd,
	output tag_lookup_pkg::tag_index_t   tag_hash_table1_raddr,
	output logic                         tag_value_rd,
	output tag_lookup_pkg::tag_index_t   tag_value_raddr
);

	tag_lookup_pkg::lookup_state_t state_q;
	tag_lookup_pkg::tag_key_t      key_q;
	pu_io_pkg::pu_id_t             pid_q;
	logic [2:0]                    num_q;
	logic                          hit0;
	logic                          hit1;
	logic                          tables_ack;

	// Bucket hits on valid bit and key match.
	assign hit0 = tag_hash_table0_rdata[`TAG_BUCKET_NBITS-1] &&
		(tag_hash_table0_rdata[`TAG_BUCKET_NBITS-2 -: `TAG_KEY_NBITS] == key_q);
	assign hit1 = tag_hash_table1_rdata[`TAG_BUCKET_NBITS-1] &&
		(tag_hash_table1_rdata[`TAG_BUCKET_NBITS-2 -: `TAG_KEY_NBITS] == key_q);
	assign tables_ack = tag_hash_table0_ack & tag_hash_table1_ack;

	// ------------------------------
	// Control and strobes.
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q                 <= tag_lookup_pkg::st_idle;
			tag_hash_table0_rd      <= 1'b0;
			tag_hash_table1_rd      <= 1'b0;
			tag_value_rd            <= 1'b0;
			tag_lookup_valid        <= 1'b0;
			tag_lookup_status_valid <= 1'b0;
		end else begin
			tag_hash_table0_rd      <= 1'b0;
			tag_hash_table1_rd      <= 1'b0;
			tag_value_rd            <= 1'b0;
			tag_lookup_valid        <= 1'b0;
			tag_lookup_status_valid <= 1'b0;
			case (state_q)
				tag_lookup_pkg::st_idle: begin
					if (tag_key_valid) begin
						tag_hash_table0_rd <= 1'b1;
						tag_hash_table1_rd <= 1'b1;
						state_q            <= tag_lookup_pkg::st_read_tables;
					end
				end
				tag_lookup_pkg::st_read_tables: begin
					state_q <= tag_lookup_pkg::st_compare;
				end
				tag_lookup_pkg::st_compare: begin
					if (tables_ack) begin
						if (hit0 || hit1) begin
							tag_value_rd <= 1'b1;
							state_q      <= tag_lookup_pkg::st_read_value;
						end else begin
							tag_lookup_status_valid <= 1'b1;
							state_q                 <= tag_lookup_pkg::st_idle;
						end
					end
				end
				tag_lookup_pkg::st_read_value: begin
					state_q <= tag_lookup_pkg::st_respond;
				end
				tag_lookup_pkg::st_respond: begin
					if (tag_value_ack) begin
						tag_lookup_valid        <= 1'b1;
						tag_lookup_status_valid <= 1'b1;
						state_q                 <= tag_lookup_pkg::st_idle;
					end
				end
				default: state_q <= tag_lookup_pkg::st_idle;
			endcase
		end
	end

	// ------------------------------
	// Key, addresses and results.
	always_ff @(posedge clk) begin
		if (state_q == tag_lookup_pkg::st_idle && tag_key_valid) begin
			key_q                 <= tag_key;
			pid_q                 <= tag_pid;
			tag_hash_table0_raddr <= tag_lookup_pkg::hash0(tag_key);
			tag_hash_table1_raddr <= tag_lookup_pkg::hash1(tag_key);
		end
		if (state_q == tag_lookup_pkg::st_compare && tables_ack) begin
			tag_lookup_status_pid <= pid_q;
			// Table 0 wins when both hit.
			if (hit0) begin
				tag_value_raddr   <= tag_hash_table0_rdata[3 +: `TAG_TABLE_DEPTH_NBITS];
				num_q             <= tag_hash_table0_rdata[2:0];
				tag_lookup_status <= tag_lookup_pkg::status_hit0;
			end else if (hit1) begin
				tag_value_raddr   <= tag_hash_table1_rdata[3 +: `TAG_TABLE_DEPTH_NBITS];
				num_q             <= tag_hash_table1_rdata[2:0];
				tag_lookup_status <= tag_lookup_pkg::status_hit1;
			end else begin
				tag_lookup_status <= tag_lookup_pkg::status_miss;
			end
		end
		if (state_q == tag_lookup_pkg::st_respond && tag_value_ack) begin
			tag_lookup_result     <= tag_value_rdata;
			tag_lookup_result_num <= num_q;
			tag_lookup_result_pid <= pid_q;
		end
	end

endmodule

// File: source/rr_arbiter.sv
// Round-robin arbiter.
// Grants the first requester after the last winner, one pulse per grant.

`include "tag_defines.svh"

module rr_arbiter (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   en,
	input  logic [`TAG_NUM_PU-1:0] req,
	output pu_io_pkg::pu_id_t      sel,
	output logic                   gnt
);

	pu_io_pkg::pu_id_t last_q;
	pu_io_pkg::pu_id_t cand;
	pu_io_pkg::pu_id_t pick;
	logic              found;

	// Search starts one past the last winner.
	always_comb begin
		found = 1'b0;
		pick  = last_q;
		cand  = last_q;
		for (int i = 1; i <= `TAG_NUM_PU; i++) begin
			cand = pu_io_pkg::pu_id_t'((int'(last_q) + i) % `TAG_NUM_PU);
			if (!found && req[cand]) begin
				found = 1'b1;
				pick  = cand;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gnt    <= 1'b0;
			last_q <= '0;
		end else begin
			gnt <= en & found;
			if (en && found) begin
				last_q <= pick;
			end
		end
	end

	// Pointer holds the winner while gnt pulses.
	assign sel = last_q;

endmodule

// File: source/tag_lookup_pkg.sv
// Tag lookup types, status codes and the two hash rules.

`include "tag_defines.svh"

package tag_lookup_pkg;

	typedef logic [`TAG_KEY_NBITS-1:0] tag_key_t;
	typedef logic [`TAG_TABLE_DEPTH_NBITS-1:0] tag_index_t;
	// Valid, stored key, value index, count. Top down.
	typedef logic [`TAG_BUCKET_NBITS-1:0] tag_bucket_t;
	typedef logic [`TAG_VALUE_NBITS-1:0] tag_value_t;
	typedef logic [3:0] tag_status_t;

	// ------------------------------
	// Status codes.
	localparam tag_status_t status_hit0 = 4'd1;
	localparam tag_status_t status_hit1 = 4'd2;
	localparam tag_status_t status_miss = 4'd8;

	typedef enum logic [2:0] {
		st_idle,
		st_read_tables,
		st_compare,
		st_read_value,
		st_respond
	} lookup_state_t;

	// ------------------------------
	// Table 0 takes the low key bits.
	function automatic tag_index_t hash0(input tag_key_t key);
		return key[5:0];
	endfunction

	// Table 1 folds the top nibble into the middle bits.
	function automatic tag_index_t hash1(input tag_key_t key);
		return key[11:6] ^ {2'b00, key[15:12]};
	endfunction

endpackage

// File: source/pu_io_pkg.sv
// PU request side types.
// Ids, request address and data, register port words.

`include "tag_defines.svh"

package pu_io_pkg;

	// Requester id.
	typedef logic [`TAG_PU_ID_NBITS-1:0] pu_id_t;

	// ------------------------------
	// PU write command.
	typedef logic [`TAG_IO_ADDR_NBITS-1:0] io_addr_t;
	typedef logic [`TAG_IO_DATA_NBITS-1:0] io_data_t;

	// ------------------------------
	// Register port address and data.
	typedef logic [`TAG_REG_NBITS-1:0] reg_word_t;

endpackage

// File: source/tag_defines.svh
// Tag lookup block constants.
// PU count, bus widths, memory depths and the request region code.

`ifndef TAG_DEFINES_SVH
`define TAG_DEFINES_SVH

// ------------------------------
// PU request side.
`define TAG_NUM_PU          4
`define TAG_PU_ID_NBITS     2
`define TAG_IO_ADDR_NBITS   16
`define TAG_IO_DATA_NBITS   32
`define TAG_REQ_REGION      4'hA

// ------------------------------
// Lookup tables and values.
`define TAG_KEY_NBITS           16
`define TAG_TABLE_DEPTH_NBITS   6
`define TAG_VALUE_DEPTH_NBITS   6
`define TAG_VALUE_NBITS         32
`define TAG_BUCKET_NBITS        26

// Register port.
`define TAG_REG_NBITS   32

// Idle cycles after each grant.
`define TAG_ARB_HOLDOFF 7

`endif
